//--- Makefile
TOP = datapathTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir obj_dir -f build.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

//--- alu/alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combinational ALU, Y against the bus, 64-bit result for Z
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module alu (
  input  datapathPkg::wordT    yQ,
  input  datapathPkg::wordT    busData,
  input  logic                 opAdd,
  input  logic                 opSub,
  input  logic                 opMul,
  input  logic                 opDiv,
  input  logic                 opAnd,
  input  logic                 opOr,
  input  logic                 opShr,
  input  logic                 opShra,
  input  logic                 opShl,
  input  logic                 opRor,
  input  logic                 opRol,
  input  logic                 opNeg,
  input  logic                 opNot,
  input  logic                 opIncPc,
  output datapathPkg::productT aluResult
);

  logic [datapathPkg::shiftWidth-1:0] shAmt;
  datapathPkg::productT               mulFull;
  datapathPkg::productT               rotRight;
  datapathPkg::productT               rotLeft;
  datapathPkg::wordT                  divQuot;
  datapathPkg::wordT                  divRem;
  datapathPkg::wordT                  lowWord;
  datapathPkg::wordT                  highWord;
  logic                               divByZero;
  logic                               divByMinusOne;

  assign shAmt = busData[datapathPkg::shiftWidth-1:0];

  // both operands signed so the product is sign extended to 64 bits
  assign mulFull = $signed(yQ) * $signed(busData);

  // rotate through a doubled copy of Y
  assign rotRight = {yQ, yQ} >> shAmt;
  assign rotLeft = {yQ, yQ} << shAmt;

  assign divByZero = (busData == '0);
  assign divByMinusOne = (busData == '1);

  // signed divide, remainder takes the dividend's sign
  always_comb begin
    if (divByZero) begin
      divQuot = '1;
      divRem = yQ;
    end else if (divByMinusOne) begin
      // most negative dividend wraps instead of overflowing
      divQuot = -yQ;
      divRem = '0;
    end else begin
      divQuot = $signed(yQ) / $signed(busData);
      divRem = $signed(yQ) % $signed(busData);
    end
  end

  // op strobes are one-hot, none raised gives zero
  always_comb begin
    lowWord = '0;
    highWord = '0;
    if (opAdd) begin
      lowWord = yQ + busData;
    end else if (opSub) begin
      lowWord = yQ - busData;
    end else if (opMul) begin
      lowWord = mulFull[0 +: datapathPkg::dataWidth];
      highWord = mulFull[datapathPkg::dataWidth +: datapathPkg::dataWidth];
    end else if (opDiv) begin
      lowWord = divQuot;
      highWord = divRem;
    end else if (opAnd) begin
      lowWord = yQ & busData;
    end else if (opOr) begin
      lowWord = yQ | busData;
    end else if (opShr) begin
      lowWord = yQ >> shAmt;
    end else if (opShra) begin
      lowWord = $signed(yQ) >>> shAmt;
    end else if (opShl) begin
      lowWord = yQ << shAmt;
    end else if (opRor) begin
      lowWord = rotRight[0 +: datapathPkg::dataWidth];
    end else if (opRol) begin
      lowWord = rotLeft[datapathPkg::dataWidth +: datapathPkg::dataWidth];
    end else if (opNeg) begin
      lowWord = -busData;
    end else if (opNot) begin
      lowWord = ~busData;
    end else if (opIncPc) begin
      lowWord = busData + 1'b1;
    end
  end

  assign aluResult = {highWord, lowWord};

endmodule

`default_nettype wire

//--- build.f
common/datapathPkg.sv
design/registerFile.sv
design/datapathRegs.sv
design/busMux.sv
alu/alu.sv
design/datapath.sv
testbench/datapath_assert.sv
testbench/datapathTb.sv

//--- common/datapathPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths, counts and word types of the datapath
// referenced by scoped name from the RTL blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package datapathPkg;

  // word width and general register count
  localparam int dataWidth = 32;
  localparam int numRegs = 16;

  // low bus bits taken as the shift or rotate count
  localparam int shiftWidth = 5;

  // bus source slots, the general registers occupy 0 to numRegs-1
  localparam int hiSlot = numRegs;
  localparam int loSlot = numRegs + 1;
  localparam int zHighSlot = numRegs + 2;
  localparam int zLowSlot = numRegs + 3;
  localparam int pcSlot = numRegs + 4;
  localparam int mdrSlot = numRegs + 5;
  localparam int inPortSlot = numRegs + 6;
  localparam int irSlot = numRegs + 7;

  localparam int numBusSources = irSlot + 1;
  localparam int busSelWidth = $clog2(numBusSources);

  // one bus word
  typedef logic [dataWidth-1:0] wordT;

  // Z double word, upper half HI-style and lower half LO-style
  typedef logic [2*dataWidth-1:0] productT;

  // general register contents as seen by the bus mux
  typedef wordT [numRegs-1:0] regArrayT;

endpackage

`default_nettype wire

//--- design/busMux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single shared bus driven by the one-hot out-strobes
// zero on the bus when no strobe is raised
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module busMux (
  input  datapathPkg::regArrayT             regQ,
  input  datapathPkg::wordT                 pcQ,
  input  datapathPkg::wordT                 irQ,
  input  datapathPkg::wordT                 mdrQ,
  input  datapathPkg::wordT                 hiQ,
  input  datapathPkg::wordT                 loQ,
  input  datapathPkg::wordT                 inPortQ,
  input  datapathPkg::productT              zQ,
  input  logic [datapathPkg::numRegs-1:0]   regOut,
  input  logic                              hiOut,
  input  logic                              loOut,
  input  logic                              zHighOut,
  input  logic                              zLowOut,
  input  logic                              pcOut,
  input  logic                              mdrOut,
  input  logic                              inPortOut,
  input  logic                              irOut,
  output datapathPkg::wordT                 busData
);

  logic [datapathPkg::numBusSources-1:0] outVec;
  logic [datapathPkg::busSelWidth-1:0]   srcSel;
  logic                                  anyOut;
  datapathPkg::wordT                     srcWord [2**datapathPkg::busSelWidth];

  // strobes gathered in slot order
  always_comb begin
    outVec = '0;
    outVec[datapathPkg::numRegs-1:0] = regOut;
    outVec[datapathPkg::hiSlot] = hiOut;
    outVec[datapathPkg::loSlot] = loOut;
    outVec[datapathPkg::zHighSlot] = zHighOut;
    outVec[datapathPkg::zLowSlot] = zLowOut;
    outVec[datapathPkg::pcSlot] = pcOut;
    outVec[datapathPkg::mdrSlot] = mdrOut;
    outVec[datapathPkg::inPortSlot] = inPortOut;
    outVec[datapathPkg::irSlot] = irOut;
  end

  // source words in the same order, unused slots read zero
  always_comb begin
    for (int i = 0; i < 2**datapathPkg::busSelWidth; i++) begin
      srcWord[i] = '0;
    end
    for (int i = 0; i < datapathPkg::numRegs; i++) begin
      srcWord[i] = regQ[i];
    end
    srcWord[datapathPkg::hiSlot] = hiQ;
    srcWord[datapathPkg::loSlot] = loQ;
    srcWord[datapathPkg::zHighSlot] = zQ[datapathPkg::dataWidth +: datapathPkg::dataWidth];
    srcWord[datapathPkg::zLowSlot] = zQ[0 +: datapathPkg::dataWidth];
    srcWord[datapathPkg::pcSlot] = pcQ;
    srcWord[datapathPkg::mdrSlot] = mdrQ;
    srcWord[datapathPkg::inPortSlot] = inPortQ;
    srcWord[datapathPkg::irSlot] = irQ;
  end

  // one-hot to index, OR of the active slot numbers
  always_comb begin
    srcSel = '0;
    for (int i = 0; i < datapathPkg::numBusSources; i++) begin
      if (outVec[i]) begin
        srcSel = srcSel | i[datapathPkg::busSelWidth-1:0];
      end
    end
  end

  assign anyOut = |outVec;
  assign busData = anyOut ? srcWord[srcSel] : '0;

endmodule

`default_nettype wire

//--- design/datapath.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single-bus datapath top, driven by level strobes from outside
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module datapath (
  input  logic                            clock,
  input  logic                            arstN,
  input  logic [datapathPkg::numRegs-1:0] regIn,
  input  logic [datapathPkg::numRegs-1:0] regOut,
  input  logic                            hiIn,
  input  logic                            loIn,
  input  logic                            hiOut,
  input  logic                            loOut,
  input  logic                            zIn,
  input  logic                            zHighOut,
  input  logic                            zLowOut,
  input  logic                            pcIn,
  input  logic                            pcOut,
  input  logic                            irIn,
  input  logic                            irOut,
  input  logic                            marIn,
  input  logic                            mdrIn,
  input  logic                            mdrOut,
  input  logic                            mdMuxRead,
  input  logic                            yIn,
  input  logic                            inPortIn,
  input  logic                            inPortOut,
  input  logic                            opAdd,
  input  logic                            opSub,
  input  logic                            opMul,
  input  logic                            opDiv,
  input  logic                            opAnd,
  input  logic                            opOr,
  input  logic                            opShr,
  input  logic                            opShra,
  input  logic                            opShl,
  input  logic                            opRor,
  input  logic                            opRol,
  input  logic                            opNeg,
  input  logic                            opNot,
  input  logic                            opIncPc,
  input  datapathPkg::wordT               memData,
  input  datapathPkg::wordT               inPortData,
  output datapathPkg::wordT               busData,
  output datapathPkg::wordT               memAddr
);

  datapathPkg::regArrayT regQ;
  datapathPkg::wordT     pcQ;
  datapathPkg::wordT     irQ;
  datapathPkg::wordT     mdrQ;
  datapathPkg::wordT     yQ;
  datapathPkg::wordT     hiQ;
  datapathPkg::wordT     loQ;
  datapathPkg::wordT     inPortQ;
  datapathPkg::productT  zQ;
  datapathPkg::productT  aluResult;

  registerFile i_registerFile (
    .clock   (clock),
    .arstN   (arstN),
    .regIn   (regIn),
    .busData (busData),
    .regQ    (regQ)
  );

  datapathRegs i_datapathRegs (
    .clock      (clock),
    .arstN      (arstN),
    .busData    (busData),
    .memData    (memData),
    .inPortData (inPortData),
    .aluResult  (aluResult),
    .pcIn       (pcIn),
    .irIn       (irIn),
    .marIn      (marIn),
    .mdrIn      (mdrIn),
    .mdMuxRead  (mdMuxRead),
    .yIn        (yIn),
    .hiIn       (hiIn),
    .loIn       (loIn),
    .zIn        (zIn),
    .inPortIn   (inPortIn),
    .pcQ        (pcQ),
    .irQ        (irQ),
    .mdrQ       (mdrQ),
    .yQ         (yQ),
    .hiQ        (hiQ),
    .loQ        (loQ),
    .inPortQ    (inPortQ),
    .zQ         (zQ),
    .memAddr    (memAddr)
  );

  // bus source selection
  busMux i_busMux (
    .regQ      (regQ),
    .pcQ       (pcQ),
    .irQ       (irQ),
    .mdrQ      (mdrQ),
    .hiQ       (hiQ),
    .loQ       (loQ),
    .inPortQ   (inPortQ),
    .zQ        (zQ),
    .regOut    (regOut),
    .hiOut     (hiOut),
    .loOut     (loOut),
    .zHighOut  (zHighOut),
    .zLowOut   (zLowOut),
    .pcOut     (pcOut),
    .mdrOut    (mdrOut),
    .inPortOut (inPortOut),
    .irOut     (irOut),
    .busData   (busData)
  );

  // operand A from Y, operand B from the bus
  alu i_alu (
    .yQ        (yQ),
    .busData   (busData),
    .opAdd     (opAdd),
    .opSub     (opSub),
    .opMul     (opMul),
    .opDiv     (opDiv),
    .opAnd     (opAnd),
    .opOr      (opOr),
    .opShr     (opShr),
    .opShra    (opShra),
    .opShl     (opShl),
    .opRor     (opRor),
    .opRol     (opRol),
    .opNeg     (opNeg),
    .opNot     (opNot),
    .opIncPc   (opIncPc),
    .aluResult (aluResult)
  );

endmodule

`default_nettype wire

//--- design/datapathRegs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// special registers around the bus: PC, IR, MAR, MDR, Y, HI, LO, Z
// and the input port; each loads on its strobe at the clock edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module datapathRegs (
  input  logic                 clock,
  input  logic                 arstN,
  input  datapathPkg::wordT    busData,
  input  datapathPkg::wordT    memData,
  input  datapathPkg::wordT    inPortData,
  input  datapathPkg::productT aluResult,
  input  logic                 pcIn,
  input  logic                 irIn,
  input  logic                 marIn,
  input  logic                 mdrIn,
  input  logic                 mdMuxRead,
  input  logic                 yIn,
  input  logic                 hiIn,
  input  logic                 loIn,
  input  logic                 zIn,
  input  logic                 inPortIn,
  output datapathPkg::wordT    pcQ,
  output datapathPkg::wordT    irQ,
  output datapathPkg::wordT    mdrQ,
  output datapathPkg::wordT    yQ,
  output datapathPkg::wordT    hiQ,
  output datapathPkg::wordT    loQ,
  output datapathPkg::wordT    inPortQ,
  output datapathPkg::productT zQ,
  output datapathPkg::wordT    memAddr
);

  datapathPkg::wordT marQ;
  datapathPkg::wordT mdrD;

  // MDR takes memory data on a read, bus data otherwise
  assign mdrD = mdMuxRead ? memData : busData;

  // fetch path registers
  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      pcQ  <= '0;
      irQ  <= '0;
      marQ <= '0;
      mdrQ <= '0;
    end else begin
      if (pcIn)  pcQ  <= busData;
      if (irIn)  irQ  <= busData;
      if (marIn) marQ <= busData;
      if (mdrIn) mdrQ <= mdrD;
    end
  end

  // ALU operand, result and port registers
  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      yQ      <= '0;
      hiQ     <= '0;
      loQ     <= '0;
      zQ      <= '0;
      inPortQ <= '0;
    end else begin
      if (yIn)      yQ      <= busData;
      if (hiIn)     hiQ     <= busData;
      if (loIn)     loQ     <= busData;
      if (zIn)      zQ      <= aluResult;
      if (inPortIn) inPortQ <= inPortData;
    end
  end

  // address goes straight out of MAR
  assign memAddr = marQ;

endmodule

`default_nettype wire

//--- design/registerFile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sixteen general registers loaded from the bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module registerFile (
  input  logic                              clock,
  input  logic                              arstN,
  input  logic [datapathPkg::numRegs-1:0]   regIn,
  input  datapathPkg::wordT                 busData,
  output datapathPkg::regArrayT             regQ
);

  // one register per slot, each with its own load strobe
  for (genvar r = 0; r < datapathPkg::numRegs; r++) begin : g_reg
    always_ff @(posedge clock or negedge arstN) begin
      if (!arstN) begin
        regQ[r] <= '0;
      end else if (regIn[r]) begin
        regQ[r] <= busData;
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/datapathTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// drives the datapath through reset, register moves, ALU ops, fetch
// and port capture, and checks results against a reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module datapathTb;

  localparam int clockPeriod = 8;
  localparam int numTrials = 20;
  localparam int numOps = 14;
  localparam int watchdogCycles = numTrials * numOps * 8 + 500;

  // in-strobe positions with the general registers first
  localparam int inHi = datapathPkg::numRegs;
  localparam int inLo = datapathPkg::numRegs + 1;
  localparam int inZ = datapathPkg::numRegs + 2;
  localparam int inPc = datapathPkg::numRegs + 3;
  localparam int inIr = datapathPkg::numRegs + 4;
  localparam int inMar = datapathPkg::numRegs + 5;
  localparam int inMdr = datapathPkg::numRegs + 6;
  localparam int inY = datapathPkg::numRegs + 7;
  localparam int inPort = datapathPkg::numRegs + 8;
  localparam int numIn = datapathPkg::numRegs + 9;

  // op order is add sub mul div and or shr shra shl ror rol neg not incPc
  localparam int opAddIdx = 0;
  localparam int opMulIdx = 2;
  localparam int opIncPcIdx = 13;

  logic clock;
  logic arstN;
  logic [datapathPkg::numBusSources-1:0] outVec;
  logic [numIn-1:0] inVec;
  logic [numOps-1:0] opVec;
  logic mdMuxRead;
  datapathPkg::wordT memData;
  datapathPkg::wordT inPortData;
  datapathPkg::wordT busData;
  datapathPkg::wordT memAddr;

  logic [31:0] lfsrState = 32'hd427;
  int errorCount = 0;
  int checkCount = 0;

  datapath i_datapath (
    .clock      (clock),
    .arstN      (arstN),
    .regIn      (inVec[datapathPkg::numRegs-1:0]),
    .regOut     (outVec[datapathPkg::numRegs-1:0]),
    .hiIn       (inVec[inHi]),
    .loIn       (inVec[inLo]),
    .hiOut      (outVec[datapathPkg::hiSlot]),
    .loOut      (outVec[datapathPkg::loSlot]),
    .zIn        (inVec[inZ]),
    .zHighOut   (outVec[datapathPkg::zHighSlot]),
    .zLowOut    (outVec[datapathPkg::zLowSlot]),
    .pcIn       (inVec[inPc]),
    .pcOut      (outVec[datapathPkg::pcSlot]),
    .irIn       (inVec[inIr]),
    .irOut      (outVec[datapathPkg::irSlot]),
    .marIn      (inVec[inMar]),
    .mdrIn      (inVec[inMdr]),
    .mdrOut     (outVec[datapathPkg::mdrSlot]),
    .mdMuxRead  (mdMuxRead),
    .yIn        (inVec[inY]),
    .inPortIn   (inVec[inPort]),
    .inPortOut  (outVec[datapathPkg::inPortSlot]),
    .opAdd      (opVec[0]),
    .opSub      (opVec[1]),
    .opMul      (opVec[2]),
    .opDiv      (opVec[3]),
    .opAnd      (opVec[4]),
    .opOr       (opVec[5]),
    .opShr      (opVec[6]),
    .opShra     (opVec[7]),
    .opShl      (opVec[8]),
    .opRor      (opVec[9]),
    .opRol      (opVec[10]),
    .opNeg      (opVec[11]),
    .opNot      (opVec[12]),
    .opIncPc    (opVec[13]),
    .memData    (memData),
    .inPortData (inPortData),
    .busData    (busData),
    .memAddr    (memAddr)
  );

  initial begin
    clock = 1'b0;
    forever #(clockPeriod / 2) clock = ~clock;
  end

  // Galois LFSR stepped once per bit taken
  function automatic datapathPkg::wordT nextWord();
    datapathPkg::wordT w;
    w = '0;
    for (int i = 0; i < datapathPkg::dataWidth; i++) begin
      w = {w[datapathPkg::dataWidth-2:0], lfsrState[0]};
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
    end
    return w;
  endfunction

  function automatic logic [numIn-1:0] bitOf(input int idx);
    logic [numIn-1:0] m;
    m = '0;
    m[idx] = 1'b1;
    return m;
  endfunction

  // expected Z contents for op applied to A and B
  function automatic datapathPkg::productT refAlu(input int op, input datapathPkg::wordT a,
                                                  input datapathPkg::wordT b);
    int sa;
    int sb;
    int sh;
    longint prod;
    datapathPkg::wordT lo;
    datapathPkg::wordT hi;
    sa = a;
    sb = b;
    sh = int'(b[4:0]);
    prod = longint'(sa) * longint'(sb);
    lo = '0;
    hi = '0;
    case (op)
      0: lo = a + b;
      1: lo = a - b;
      2: begin
        lo = prod[31:0];
        hi = prod[63:32];
      end
      3: begin
        if (b == '0) begin
          lo = '1;
          hi = a;
        end else if (sb == -1) begin
          // quotient wraps for the most negative dividend
          lo = 32'd0 - a;
          hi = '0;
        end else begin
          lo = sa / sb;
          hi = sa % sb;
        end
      end
      4: lo = a & b;
      5: lo = a | b;
      6: lo = a >> sh;
      7: lo = sa >>> sh;
      8: lo = a << sh;
      9: lo = (a >> sh) | (a << (32 - sh));
      10: lo = (a << sh) | (a >> (32 - sh));
      11: lo = 32'd0 - b;
      12: lo = ~b;
      13: lo = b + 32'd1;
      default: lo = '0;
    endcase
    return {hi, lo};
  endfunction

  task automatic checkWord(input datapathPkg::wordT got, input datapathPkg::wordT exp,
                           input string msg);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic checkProduct(input datapathPkg::productT got, input datapathPkg::productT exp,
                              input string msg);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  // one cycle of strobes where a negative src or op means none
  task automatic step(input int src, input logic [numIn-1:0] dst, input int op,
                      input logic rd);
    logic [datapathPkg::numBusSources-1:0] o;
    logic [numOps-1:0] p;
    o = '0;
    p = '0;
    if (src >= 0) o[src] = 1'b1;
    if (op >= 0) p[op] = 1'b1;
    @(posedge clock);
    outVec <= o;
    inVec <= dst;
    opVec <= p;
    mdMuxRead <= rd;
  endtask

  task automatic loadMdr(input datapathPkg::wordT w);
    step(-1, bitOf(inMdr), -1, 1'b1);
    memData <= w;
  endtask

  task automatic readBus(input int src, output datapathPkg::wordT v);
    step(src, '0, -1, 1'b0);
    @(negedge clock);
    v = busData;
  endtask

  // load Y, load Z with the op, read Z back in two halves
  task automatic runOp(input int op, input datapathPkg::wordT a, input datapathPkg::wordT b);
    datapathPkg::wordT lo;
    datapathPkg::wordT hi;
    loadMdr(a);
    step(datapathPkg::mdrSlot, bitOf(inY), -1, 1'b0);
    loadMdr(b);
    step(datapathPkg::mdrSlot, bitOf(inZ), op, 1'b0);
    readBus(datapathPkg::zLowSlot, lo);
    readBus(datapathPkg::zHighSlot, hi);
    checkProduct({hi, lo}, refAlu(op, a, b), $sformatf("op %0d a %h b %h", op, a, b));
  endtask

  initial begin
    #(watchdogCycles * clockPeriod);
    $display("timeout: the run did not finish within %0d cycles", watchdogCycles);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    datapathPkg::wordT v;
    datapathPkg::wordT w;
    datapathPkg::wordT a;
    datapathPkg::wordT b;
    datapathPkg::wordT expPc;
    datapathPkg::productT expZ;
    datapathPkg::wordT moved [datapathPkg::numRegs + 2];
    int dstIdx;
    int srcIdx;
    arstN = 1'b0;
    outVec = '0;
    inVec = '0;
    opVec = '0;
    mdMuxRead = 1'b0;
    memData = '0;
    inPortData = '0;
    repeat (16) @(posedge clock);
    arstN <= 1'b1;

    // every source reads zero after reset
    for (int s = 0; s < datapathPkg::numBusSources; s++) begin
      readBus(s, v);
      checkWord(v, '0, $sformatf("reset bus slot %0d", s));
    end
    checkWord(memAddr, '0, "reset memAddr");

    // MDR to each general register and then HI and LO
    for (int r = 0; r < datapathPkg::numRegs + 2; r++) begin
      dstIdx = (r < datapathPkg::numRegs) ? r : ((r == datapathPkg::numRegs) ? inHi : inLo);
      srcIdx = (r < datapathPkg::numRegs) ? r :
               ((r == datapathPkg::numRegs) ? datapathPkg::hiSlot : datapathPkg::loSlot);
      w = nextWord();
      moved[r] = w;
      loadMdr(w);
      step(datapathPkg::mdrSlot, bitOf(dstIdx), -1, 1'b0);
      readBus(srcIdx, v);
      checkWord(v, w, $sformatf("move to destination %0d", r));
    end

    // each destination keeps its own word once the MDR has moved on
    for (int r = 0; r < datapathPkg::numRegs + 2; r++) begin
      srcIdx = (r < datapathPkg::numRegs) ? r :
               ((r == datapathPkg::numRegs) ? datapathPkg::hiSlot : datapathPkg::loSlot);
      readBus(srcIdx, v);
      checkWord(v, moved[r], $sformatf("readback of destination %0d", r));
    end

    // MDR loaded over the bus while memData still holds another word
    step(datapathPkg::hiSlot, bitOf(inMdr), -1, 1'b0);
    readBus(datapathPkg::mdrSlot, v);
    checkWord(v, moved[datapathPkg::numRegs], "bus into MDR");

    // random operands then B of 0 and 31 for the shift and divide corners
    for (int op = 0; op < numOps; op++) begin
      for (int t = 0; t < numTrials; t++) begin
        a = nextWord();
        b = nextWord();
        runOp(op, a, b);
      end
      a = nextWord();
      runOp(op, a, 32'd0);
      a = nextWord();
      runOp(op, a, 32'd31);
    end

    // fetch passes from a random start address
    expPc = nextWord();
    loadMdr(expPc);
    step(datapathPkg::mdrSlot, bitOf(inPc), -1, 1'b0);
    for (int t = 0; t < numTrials; t++) begin
      w = nextWord();
      step(datapathPkg::pcSlot, bitOf(inMar) | bitOf(inZ), opIncPcIdx, 1'b0);
      step(datapathPkg::zLowSlot, bitOf(inPc), -1, 1'b0);
      loadMdr(w);
      step(datapathPkg::mdrSlot, bitOf(inIr), -1, 1'b0);
      readBus(datapathPkg::pcSlot, v);
      checkWord(memAddr, expPc, "fetch memAddr");
      checkWord(v, expPc + 32'd1, "fetch PC");
      readBus(datapathPkg::irSlot, v);
      checkWord(v, w, "fetch IR");
      expPc = expPc + 32'd1;
    end

    // Z halves written back into general registers
    a = nextWord();
    b = nextWord();
    runOp(opAddIdx, a, b);
    expZ = refAlu(opAddIdx, a, b);
    step(datapathPkg::zLowSlot, bitOf(3), -1, 1'b0);
    readBus(3, v);
    checkWord(v, expZ[31:0], "write-back of sum");
    runOp(opMulIdx, a, b);
    expZ = refAlu(opMulIdx, a, b);
    step(datapathPkg::zHighSlot, bitOf(7), -1, 1'b0);
    readBus(7, v);
    checkWord(v, expZ[63:32], "write-back of product high word");

    // input port capture and move
    w = nextWord();
    step(-1, bitOf(inPort), -1, 1'b0);
    inPortData <= w;
    step(datapathPkg::inPortSlot, bitOf(12), -1, 1'b0);
    readBus(12, v);
    checkWord(v, w, "input port to register");
    step(-1, '0, -1, 1'b0);
    @(posedge clock);

    $display("checks %0d errors %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/datapath_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// strobe and reset assertions, bound into the datapath
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module datapathAssert (
  input logic                                    clock,
  input logic                                    arstN,
  input logic [datapathPkg::numBusSources-1:0]   outStrobes,
  input logic                                    zIn,
  input logic [13:0]                             opStrobes,
  input datapathPkg::wordT                       memAddr
);

  // only one source may drive the bus
  outOneHot : assert property (@(posedge clock) disable iff (!arstN) $onehot0(outStrobes))
    else $error("more than one out-strobe drives the bus");

  opOneHot : assert property (@(posedge clock) disable iff (!arstN)
                              zIn |-> $onehot0(opStrobes))
    else $error("several op strobes raised while Z loads");

  resetAddr : assert property (@(posedge clock) !arstN |-> memAddr == '0)
    else $error("memAddr is not zero during reset");

endmodule

bind datapath datapathAssert i_datapathAssert (
  .clock      (clock),
  .arstN      (arstN),
  .outStrobes ({irOut, inPortOut, mdrOut, pcOut, zLowOut, zHighOut, loOut, hiOut, regOut}),
  .zIn        (zIn),
  .opStrobes  ({opIncPc, opNot, opNeg, opRol, opRor, opShl, opShra, opShr,
                opOr, opAnd, opDiv, opMul, opSub, opAdd}),
  .memAddr    (memAddr)
);

`default_nettype wire
